// File: include/conv_consts.svh
// Convolution engine constants
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// Input tile geometry
`define CONV_TR 6
`define CONV_TC 6

// Kernel size, stride is fixed at 1
`define CONV_K 3

// Channel counts, one lane per output channel
`define CONV_IN_CH 2
`define CONV_OUT_CH 4

// Output tile geometry
`define CONV_OR (`CONV_TR - `CONV_K + 1)
`define CONV_OC (`CONV_TC - `CONV_K + 1)

// Taps summed into each output pixel
`define CONV_TAPS (`CONV_K * `CONV_K * `CONV_IN_CH)

`define CONV_DATA_W 8
`define CONV_ACC_W 24

`endif

// File: hdl/conv_pkg.sv
// Convolution engine types
`include "conv_consts.svh"

package conv_pkg;

    // Signed datapath values
    typedef logic signed [`CONV_DATA_W-1:0] pixel_t;
    typedef logic signed [`CONV_DATA_W-1:0] weight_t;
    typedef logic signed [`CONV_ACC_W-1:0] acc_t;

    // Input buffer address, laid out as channel, row, column
    typedef logic [$clog2(`CONV_IN_CH * `CONV_TR * `CONV_TC)-1:0] in_addr_t;

    // Weight address in one lane, laid out as channel, kernel row, kernel column
    typedef logic [$clog2(`CONV_TAPS)-1:0] w_addr_t;

    // Lane select
    typedef logic [$clog2(`CONV_OUT_CH)-1:0] lane_t;

    // Output pixel index in one channel, row major
    typedef logic [$clog2(`CONV_OR * `CONV_OC)-1:0] out_addr_t;

endpackage

// File: hdl/conv_ctrl_path.sv
// Convolution control path
`include "conv_consts.svh"

module conv_ctrl_path (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                done,
    output logic                busy,
    output conv_pkg::in_addr_t  in_addr,
    output conv_pkg::w_addr_t   w_addr,
    output logic                tap_valid,
    output logic                tap_first,
    output logic                tap_last
);

    logic                               start_q;
    logic                               start_go;
    logic                               active;
    logic                               issue;

    // Tap counters, innermost first
    logic [$clog2(`CONV_K)-1:0]         kc;
    logic [$clog2(`CONV_K)-1:0]         kr;
    logic [$clog2(`CONV_IN_CH)-1:0]     ch;
    logic [$clog2(`CONV_OC)-1:0]        ocol;
    logic [$clog2(`CONV_OR)-1:0]        orow;

    logic                               kc_wrap;
    logic                               kr_wrap;
    logic                               ch_wrap;
    logic                               oc_wrap;
    logic                               tile_end;
    logic                               first_tap;

    // Rising edge of start, ignored while a run is in flight
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start;
        end
    end

    assign start_go = start && !start_q && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (start_go) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    // Tap issue runs from the start edge until the last tap of the tile
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
        end else if (start_go) begin
            active <= 1'b1;
        end else if (issue && tile_end) begin
            active <= 1'b0;
        end
    end

    assign issue = start_go || active;

    // Carry chain of the nested counters
    assign kc_wrap   = (kc == `CONV_K - 1);
    assign kr_wrap   = kc_wrap && (kr == `CONV_K - 1);
    assign ch_wrap   = kr_wrap && (ch == `CONV_IN_CH - 1);
    assign oc_wrap   = ch_wrap && (ocol == `CONV_OC - 1);
    assign tile_end  = oc_wrap && (orow == `CONV_OR - 1);
    assign first_tap = (kc == 0) && (kr == 0) && (ch == 0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            kc   <= '0;
            kr   <= '0;
            ch   <= '0;
            ocol <= '0;
            orow <= '0;
        end else if (issue) begin
            kc <= kc_wrap ? '0 : kc + 1'b1;
            if (kc_wrap) begin
                kr <= (kr == `CONV_K - 1) ? '0 : kr + 1'b1;
            end
            if (kr_wrap) begin
                ch <= (ch == `CONV_IN_CH - 1) ? '0 : ch + 1'b1;
            end
            if (ch_wrap) begin
                ocol <= (ocol == `CONV_OC - 1) ? '0 : ocol + 1'b1;
            end
            if (oc_wrap) begin
                orow <= (orow == `CONV_OR - 1) ? '0 : orow + 1'b1;
            end
        end
    end

    // Addresses and strobes leave together from one register stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_addr   <= '0;
            w_addr    <= '0;
            tap_valid <= 1'b0;
            tap_first <= 1'b0;
            tap_last  <= 1'b0;
        end else begin
            tap_valid <= issue;
            tap_first <= issue && first_tap;
            tap_last  <= issue && ch_wrap;
            if (issue) begin
                in_addr <= conv_pkg::in_addr_t'(ch * (`CONV_TR * `CONV_TC)
                           + (orow + kr) * `CONV_TC + (ocol + kc));
                w_addr  <= conv_pkg::w_addr_t'(ch * (`CONV_K * `CONV_K)
                           + kr * `CONV_K + kc);
            end
        end
    end

endmodule

// File: hdl/in_fm_buffer.sv
// Input tile buffer
`include "conv_consts.svh"

module in_fm_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_en,
    input  conv_pkg::in_addr_t  wr_addr,
    input  conv_pkg::pixel_t    wr_data,
    input  conv_pkg::in_addr_t  rd_addr,
    input  logic                tap_valid,
    input  logic                tap_first,
    input  logic                tap_last,
    output conv_pkg::pixel_t    pixel,
    output logic                pix_valid,
    output logic                pix_first,
    output logic                pix_last
);

    // Whole input tile, all channels
    conv_pkg::pixel_t mem [`CONV_IN_CH * `CONV_TR * `CONV_TC];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        pixel <= mem[rd_addr];
    end

    // Strobes follow the read data by the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pix_valid <= 1'b0;
            pix_first <= 1'b0;
            pix_last  <= 1'b0;
        end else begin
            pix_valid <= tap_valid;
            pix_first <= tap_first;
            pix_last  <= tap_last;
        end
    end

endmodule

// File: hdl/conv_lane.sv
// Output channel lane
`include "conv_consts.svh"

module conv_lane (
    input  logic                clk,
    input  logic                rst,
    input  logic                w_wr_en,
    input  conv_pkg::w_addr_t   w_wr_addr,
    input  conv_pkg::weight_t   w_wr_data,
    input  conv_pkg::w_addr_t   w_rd_addr,
    input  conv_pkg::pixel_t    pixel,
    input  logic                pix_valid,
    input  logic                pix_first,
    input  logic                pix_last,
    output conv_pkg::acc_t      result,
    output logic                result_valid
);

    // Kernel weights of this output channel
    conv_pkg::weight_t                   w_mem [`CONV_TAPS];
    conv_pkg::weight_t                   weight;
    logic signed [2*`CONV_DATA_W-1:0]    prod;
    conv_pkg::acc_t                      prod_ext;
    conv_pkg::acc_t                      acc;

    // Weight read lines up with the pixel read in the feeder
    always_ff @(posedge clk) begin
        if (w_wr_en) begin
            w_mem[w_wr_addr] <= w_wr_data;
        end
        weight <= w_mem[w_rd_addr];
    end

    assign prod     = pixel * weight;
    assign prod_ext = conv_pkg::acc_t'(prod);

    // First tap of a pixel restarts the sum
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            if (pix_first) begin
                acc <= prod_ext;
            end else begin
                acc <= acc + prod_ext;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= pix_valid && pix_last;
        end
    end

    // Sum is complete while result_valid is high
    assign result = acc;

endmodule

// File: hdl/out_fm_writer.sv
// Output tile writer
`include "conv_consts.svh"

module out_fm_writer (
    input  logic                clk,
    input  logic                rst,
    input  conv_pkg::acc_t      result [`CONV_OUT_CH],
    input  logic                result_valid,
    input  conv_pkg::lane_t     rd_lane,
    input  conv_pkg::out_addr_t rd_addr,
    output conv_pkg::acc_t      rd_data,
    output logic                done
);

    localparam int OUT_PIX = `CONV_OR * `CONV_OC;

    // One bank per lane, indexed by output pixel
    conv_pkg::acc_t         bank [`CONV_OUT_CH][OUT_PIX];
    conv_pkg::out_addr_t    out_addr;
    logic                   last_pix;

    assign last_pix = (out_addr == OUT_PIX - 1);

    // Write pointer shared by all lanes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_addr <= '0;
        end else if (result_valid) begin
            out_addr <= last_pix ? '0 : out_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (result_valid) begin
            for (int l = 0; l < `CONV_OUT_CH; l++) begin
                bank[l][out_addr] <= result[l];
            end
        end
    end

    // Tile finished after the last pixel lands
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= result_valid && last_pix;
        end
    end

    // Readback, one cycle latency
    always_ff @(posedge clk) begin
        rd_data <= bank[rd_lane][rd_addr];
    end

endmodule

// File: hdl/conv_engine.sv
// Convolution engine top
`include "conv_consts.svh"

module conv_engine (
    input  logic                clk,
    input  logic                rst,
    input  logic                in_wr_en,
    input  conv_pkg::in_addr_t  in_wr_addr,
    input  conv_pkg::pixel_t    in_wr_data,
    input  logic                w_wr_en,
    input  conv_pkg::lane_t     w_wr_lane,
    input  conv_pkg::w_addr_t   w_wr_addr,
    input  conv_pkg::weight_t   w_wr_data,
    input  logic                start,
    input  conv_pkg::lane_t     out_rd_lane,
    input  conv_pkg::out_addr_t out_rd_addr,
    output conv_pkg::acc_t      out_rd_data,
    output logic                busy,
    output logic                done
);

    conv_pkg::in_addr_t         in_addr;
    conv_pkg::w_addr_t          w_addr;
    logic                       tap_valid;
    logic                       tap_first;
    logic                       tap_last;

    conv_pkg::pixel_t           pixel;
    logic                       pix_valid;
    logic                       pix_first;
    logic                       pix_last;

    conv_pkg::acc_t             lane_result [`CONV_OUT_CH];
    logic [`CONV_OUT_CH-1:0]    lane_valid;
    logic                       result_valid;

    conv_ctrl_path u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .done      (done),
        .busy      (busy),
        .in_addr   (in_addr),
        .w_addr    (w_addr),
        .tap_valid (tap_valid),
        .tap_first (tap_first),
        .tap_last  (tap_last)
    );

    // Single feeder broadcasting to every lane
    in_fm_buffer u_in_buf (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (in_wr_en),
        .wr_addr   (in_wr_addr),
        .wr_data   (in_wr_data),
        .rd_addr   (in_addr),
        .tap_valid (tap_valid),
        .tap_first (tap_first),
        .tap_last  (tap_last),
        .pixel     (pixel),
        .pix_valid (pix_valid),
        .pix_first (pix_first),
        .pix_last  (pix_last)
    );

    for (genvar g = 0; g < `CONV_OUT_CH; g++) begin : g_lane
        logic lane_w_en;

        // Weight writes reach only the selected lane
        assign lane_w_en = w_wr_en && (w_wr_lane == conv_pkg::lane_t'(g));

        conv_lane u_lane (
            .clk          (clk),
            .rst          (rst),
            .w_wr_en      (lane_w_en),
            .w_wr_addr    (w_wr_addr),
            .w_wr_data    (w_wr_data),
            .w_rd_addr    (w_addr),
            .pixel        (pixel),
            .pix_valid    (pix_valid),
            .pix_first    (pix_first),
            .pix_last     (pix_last),
            .result       (lane_result[g]),
            .result_valid (lane_valid[g])
        );
    end

    // Lanes share strobes and pulse together
    assign result_valid = &lane_valid;

    out_fm_writer u_out_wr (
        .clk          (clk),
        .rst          (rst),
        .result       (lane_result),
        .result_valid (result_valid),
        .rd_lane      (out_rd_lane),
        .rd_addr      (out_rd_addr),
        .rd_data      (out_rd_data),
        .done         (done)
    );

endmodule

// File: sim/tb_conv_engine.sv
// Convolution engine testbench
`include "conv_consts.svh"

module tb_conv_engine;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IN_N = `CONV_IN_CH * `CONV_TR * `CONV_TC;
    localparam int W_N = `CONV_OUT_CH * `CONV_TAPS;
    localparam int LOAD_N = (IN_N > W_N) ? IN_N : W_N;
    localparam int OUT_N = `CONV_OR * `CONV_OC;
    localparam int NUM_TESTS = 6;
    localparam int CYCLE_LIMIT = NUM_TESTS * 500;

    // Input pattern kinds
    localparam int IN_ZERO = 0;
    localparam int IN_RAMP = 1;
    localparam int IN_RAND = 2;
    localparam int IN_EXT  = 3;

    // Weight pattern kinds
    localparam int W_CENTER = 0;
    localparam int W_ONES   = 1;
    localparam int W_RAND   = 2;
    localparam int W_EXT    = 3;

    logic                clk;
    logic                rst;
    logic                in_wr_en;
    conv_pkg::in_addr_t  in_wr_addr;
    conv_pkg::pixel_t    in_wr_data;
    logic                w_wr_en;
    conv_pkg::lane_t     w_wr_lane;
    conv_pkg::w_addr_t   w_wr_addr;
    conv_pkg::weight_t   w_wr_data;
    logic                start;
    conv_pkg::lane_t     out_rd_lane;
    conv_pkg::out_addr_t out_rd_addr;
    conv_pkg::acc_t      out_rd_data;
    logic                busy;
    logic                done;

    // Test table, applied in order and back to back
    string test_name [NUM_TESTS] = '{"center_tap", "ones_ramp", "random_mix",
                                     "held_start", "zero_input", "extremes"};
    int    in_kind   [NUM_TESTS] = '{IN_RAMP, IN_RAMP, IN_RAND, IN_RAND, IN_ZERO, IN_EXT};
    int    w_kind    [NUM_TESTS] = '{W_CENTER, W_ONES, W_RAND, W_RAND, W_RAND, W_EXT};
    bit    hold      [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

    int in_tile [IN_N];
    int wt [`CONV_OUT_CH][`CONV_TAPS];
    int cycles;
    int done_count;
    int done_expected;

    conv_engine dut (
        .clk         (clk),
        .rst         (rst),
        .in_wr_en    (in_wr_en),
        .in_wr_addr  (in_wr_addr),
        .in_wr_data  (in_wr_data),
        .w_wr_en     (w_wr_en),
        .w_wr_lane   (w_wr_lane),
        .w_wr_addr   (w_wr_addr),
        .w_wr_data   (w_wr_data),
        .start       (start),
        .out_rd_lane (out_rd_lane),
        .out_rd_addr (out_rd_addr),
        .out_rd_data (out_rd_data),
        .busy        (busy),
        .done        (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Run length guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: no result after %0d cycles", cycles);
            $display(">>> FAIL");
            $fatal(1);
        end
    end

    always @(negedge clk) begin
        if (done) begin
            done_count = done_count + 1;
        end
    end

    task automatic check_value(input string name, input int lane, input int idx,
                               input int exp, input int got);
        assert (got == exp) else begin
            $display("FAILED %s lane %0d index %0d expected %0d actual %0d",
                     name, lane, idx, exp, got);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_status(input bit ok, input string what);
        assert (ok) else begin
            $display("Error: %s", what);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    function automatic int random_signed();
        return int'($urandom_range(255)) - 128;
    endfunction

    task automatic make_patterns(input int ik, input int wk);
        for (int i = 0; i < IN_N; i++) begin
            case (ik)
                IN_ZERO: in_tile[i] = 0;
                IN_RAMP: in_tile[i] = i - IN_N / 2;
                IN_RAND: in_tile[i] = random_signed();
                default: in_tile[i] = -128;
            endcase
        end
        for (int l = 0; l < `CONV_OUT_CH; l++) begin
            for (int j = 0; j < `CONV_TAPS; j++) begin
                case (wk)
                    // Channel 0, kernel row 1, kernel column 1
                    W_CENTER: wt[l][j] = (j == `CONV_K + 1) ? 1 : 0;
                    W_ONES:   wt[l][j] = 1;
                    W_RAND:   wt[l][j] = random_signed();
                    default:  wt[l][j] = -128;
                endcase
            end
        end
    endtask

    // Tile and weights share the same write cycles
    task automatic load_memories();
        for (int i = 0; i < LOAD_N; i++) begin
            @(negedge clk);
            check_status(!busy && !done, "busy or done high while loading with no start");
            in_wr_en = (i < IN_N);
            in_wr_addr = conv_pkg::in_addr_t'(i);
            in_wr_data = conv_pkg::pixel_t'(in_tile[i % IN_N]);
            w_wr_en = (i < W_N);
            w_wr_lane = conv_pkg::lane_t'((i % W_N) / `CONV_TAPS);
            w_wr_addr = conv_pkg::w_addr_t'(i % `CONV_TAPS);
            w_wr_data = conv_pkg::weight_t'(wt[(i % W_N) / `CONV_TAPS][i % `CONV_TAPS]);
        end
        @(negedge clk);
        in_wr_en = 1'b0;
        w_wr_en = 1'b0;
    endtask

    task automatic run_tile(input bit hold_high);
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        check_status(busy, "busy did not rise after the start edge");
        if (hold_high) begin
            repeat (3) @(negedge clk);
            start = 1'b0;
            @(negedge clk);
            start = 1'b1; // second rising edge while busy
        end else begin
            start = 1'b0;
        end
        while (!done) begin
            check_status(busy, "busy dropped before done");
            @(negedge clk);
        end
        check_status(busy, "busy low in the done cycle");
        done_expected = done_expected + 1;
        @(negedge clk);
        check_status(!busy, "busy still high one cycle after done");
        check_status(!done, "done lasted more than one cycle");
        if (hold_high) begin
            repeat (4) @(negedge clk);
            start = 1'b0;
        end
        repeat (4) @(negedge clk);
        check_status(!busy, "a new run began without a fresh start edge");
        check_status(done_count == done_expected, "wrong number of done pulses");
    endtask

    // Direct convolution over channel, kernel row and kernel column
    function automatic int ref_pixel(input int lane, input int r, input int c);
        int sum;
        sum = 0;
        for (int ch = 0; ch < `CONV_IN_CH; ch++) begin
            for (int kr = 0; kr < `CONV_K; kr++) begin
                for (int kc = 0; kc < `CONV_K; kc++) begin
                    sum += in_tile[ch * `CONV_TR * `CONV_TC + (r + kr) * `CONV_TC + c + kc]
                           * wt[lane][ch * `CONV_K * `CONV_K + kr * `CONV_K + kc];
                end
            end
        end
        return sum;
    endfunction

    // Reads are pipelined, data lags the address by one cycle
    task automatic read_and_compare(input int t);
        int total;
        int lane;
        int idx;
        total = `CONV_OUT_CH * OUT_N;
        for (int k = 0; k <= total; k++) begin
            @(negedge clk);
            if (k > 0) begin
                lane = (k - 1) / OUT_N;
                idx = (k - 1) % OUT_N;
                check_value(test_name[t], lane, idx,
                            ref_pixel(lane, idx / `CONV_OC, idx % `CONV_OC), out_rd_data);
            end
            if (k < total) begin
                out_rd_lane = conv_pkg::lane_t'(k / OUT_N);
                out_rd_addr = conv_pkg::out_addr_t'(k % OUT_N);
            end
        end
    endtask

    initial begin
        void'($urandom(27));
        cycles = 0;
        done_count = 0;
        done_expected = 0;
        rst = 1'b1;
        in_wr_en = 1'b0;
        in_wr_addr = '0;
        in_wr_data = '0;
        w_wr_en = 1'b0;
        w_wr_lane = '0;
        w_wr_addr = '0;
        w_wr_data = '0;
        start = 1'b0;
        out_rd_lane = '0;
        out_rd_addr = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_status(!busy && !done, "busy or done high after reset");
        for (int t = 0; t < NUM_TESTS; t++) begin
            make_patterns(in_kind[t], w_kind[t]);
            load_memories();
            run_tile(hold[t]);
            read_and_compare(t);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: all.f
+incdir+include
hdl/conv_pkg.sv
hdl/conv_ctrl_path.sv
hdl/in_fm_buffer.sv
hdl/conv_lane.sv
hdl/out_fm_writer.sv
hdl/conv_engine.sv
sim/tb_conv_engine.sv
